//--- wb_pkg.sv
////////////////////
// shared widths, unit indices and operation codes of the execution slice.
// every RTL file imports this package in its module header.
////////////////////

package wb_pkg;

   localparam int XLEN       = 32;            // data width of operands and results.
   localparam int TAG_W      = 6;             // destination register tag width.
   localparam int ID_W       = 4;             // reorder buffer id width.
   localparam int ROB_DEPTH  = 2 ** ID_W;     // one in-flight slot for every id value.
   localparam int INFL_W     = ID_W + 1;      // the in-flight count must reach ROB_DEPTH itself.

   // functional unit indices, a lower index wins the writeback port.
   localparam int N_FU       = 3;
   localparam int FU_DIV     = 0;             // the divider is rare and slow, so it goes first.
   localparam int FU_MUL     = 1;             // the multiplier pipeline drains next.
   localparam int FU_ALU     = 2;             // the ALU refills every cycle and waits last.

   localparam int MUL_STAGES = 3;             // operand, product and result stages.
   localparam int DIV_CYCLES = 32;            // one quotient bit per iteration.
   localparam int DIV_CNT_W  = $clog2(DIV_CYCLES + 1);  // holds DIV_CYCLES down to zero.

   // operation codes as they come out of decode.
   typedef enum logic [3:0]
   {
      OP_ADD  = 4'd0,
      OP_SUB  = 4'd1,
      OP_AND  = 4'd2,
      OP_OR   = 4'd3,
      OP_XOR  = 4'd4,
      OP_SLL  = 4'd5,
      OP_SRL  = 4'd6,
      OP_MUL  = 4'd7,                         // low 32 bits of the product.
      OP_DIVU = 4'd8,                         // unsigned quotient.
      OP_REMU = 4'd9                          // unsigned remainder.
   } op_t;

endpackage

//--- issue_ctrl.sv
////////////////////
// issue control, hands out reorder ids, bounds the work in flight and
// steers each accepted operation to the ALU, multiplier or divider.
////////////////////
`timescale 1ns/10ps

module issue_ctrl import wb_pkg::*;
(
   input  logic              clk,
   input  logic              rst,
   input  logic              in_valid,
   output logic              in_ready,
   input  op_t               in_op,
   input  logic [XLEN-1:0]   in_a,
   input  logic [XLEN-1:0]   in_b,
   input  logic [TAG_W-1:0]  in_tag,
   input  logic              alu_rdy,
   input  logic              mul_rdy,
   input  logic              div_rdy,
   output logic              alu_req,
   output logic              mul_req,
   output logic              div_req,
   output op_t               fu_op,
   output logic [XLEN-1:0]   fu_a,
   output logic [XLEN-1:0]   fu_b,
   output logic [TAG_W-1:0]  fu_tag,
   output logic [ID_W-1:0]   fu_id,
   input  logic              wb_fire
);

   logic              live;                   // set on the first edge after reset is released.
   logic [ID_W-1:0]   next_id;                // wraps, so ids are reused in issue order.
   logic [INFL_W-1:0] inflight;               // issued but not yet written back.
   logic              sel_mul;
   logic              sel_div;
   logic              sel_alu;
   logic              unit_rdy;
   logic              room;
   logic              fire;

   assign sel_mul  = (in_op == OP_MUL);
   assign sel_div  = (in_op == OP_DIVU) || (in_op == OP_REMU);
   assign sel_alu  = !sel_mul && !sel_div;    // everything else is plain integer work.
   assign unit_rdy = (sel_alu && alu_rdy) || (sel_mul && mul_rdy) || (sel_div && div_rdy);
   assign room     = (inflight < INFL_W'(ROB_DEPTH));
   assign in_ready = live && unit_rdy && room;
   assign fire     = in_valid && in_ready;

   assign alu_req  = fire && sel_alu;         // a request is raised only on an accepted issue.
   assign mul_req  = fire && sel_mul;
   assign div_req  = fire && sel_div;
   assign fu_op    = in_op;                   // the payload goes to all units, req picks one.
   assign fu_a     = in_a;
   assign fu_b     = in_b;
   assign fu_tag   = in_tag;
   assign fu_id    = next_id;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         live     <= 1'b0;
         next_id  <= '0;
         inflight <= '0;
      end
      else
      begin
         live <= 1'b1;
         if (fire)
            next_id <= next_id + 1'b1;
         if (fire && !wb_fire)
            inflight <= inflight + 1'b1;
         else if (!fire && wb_fire)
            inflight <= inflight - 1'b1; // issue and writeback together leave it unchanged.
      end
   end

   // the writeback side must never retire more than was issued here.
   a_infl_max: assert property (@(posedge clk) disable iff (rst)
      inflight <= INFL_W'(ROB_DEPTH));
   a_wb_owned: assert property (@(posedge clk) disable iff (rst)
      wb_fire |-> (inflight != '0));

endmodule

//--- alu_unit.sv
////////////////////
// single cycle integer ALU with one result holding register.
// the result waits in the register until the arbiter takes it.
////////////////////
`timescale 1ns/10ps

module alu_unit import wb_pkg::*;
(
   input  logic              clk,
   input  logic              rst,
   input  logic              req,
   output logic              rdy,
   input  op_t               op,
   input  logic [XLEN-1:0]   a,
   input  logic [XLEN-1:0]   b,
   input  logic [TAG_W-1:0]  tag,
   input  logic [ID_W-1:0]   id,
   output logic              res_valid,
   input  logic              res_ready,
   output logic [XLEN-1:0]   res_data,
   output logic [TAG_W-1:0]  res_tag,
   output logic [ID_W-1:0]   res_id
);

   logic [XLEN-1:0] result;

   always_comb
   begin
      case (op)
         OP_ADD:  result = a + b;
         OP_SUB:  result = a - b;
         OP_AND:  result = a & b;
         OP_OR:   result = a | b;
         OP_XOR:  result = a ^ b;
         OP_SLL:  result = a << b[4:0];       // shift amount is the low five bits.
         OP_SRL:  result = a >> b[4:0];       // logical, zeros shift in.
         default: result = '0;                // multiply and divide never reach this unit.
      endcase
   end

   assign rdy = !res_valid || res_ready;      // empty, or emptied on this edge.

   always_ff @(posedge clk)
   begin
      if (rst)
         res_valid <= 1'b0;
      else if (rdy)
         res_valid <= req;
   end

   always_ff @(posedge clk)
   begin
      if (req)
      begin
         res_data <= result;
         res_tag  <= tag;
         res_id   <= id;
      end
   end

endmodule

//--- mul_unit.sv
////////////////////
// three stage multiplier pipeline returning the low half of the product.
// stages advance only into free space, so it stalls under back-pressure.
////////////////////
`timescale 1ns/10ps

module mul_unit import wb_pkg::*;
(
   input  logic              clk,
   input  logic              rst,
   input  logic              req,
   output logic              rdy,
   input  logic [XLEN-1:0]   a,
   input  logic [XLEN-1:0]   b,
   input  logic [TAG_W-1:0]  tag,
   input  logic [ID_W-1:0]   id,
   output logic              res_valid,
   input  logic              res_ready,
   output logic [XLEN-1:0]   res_data,
   output logic [TAG_W-1:0]  res_tag,
   output logic [ID_W-1:0]   res_id
);

   logic [MUL_STAGES-1:0] stg_v;              // one valid bit per stage.
   logic [MUL_STAGES-1:0] adv;                // the stage may load on this edge.
   logic [XLEN-1:0]       s1_a;
   logic [XLEN-1:0]       s1_b;
   logic [TAG_W-1:0]      s1_tag;
   logic [ID_W-1:0]       s1_id;
   logic [2*XLEN-1:0]     s2_prod;            // full product, trimmed in the last stage.
   logic [TAG_W-1:0]      s2_tag;
   logic [ID_W-1:0]       s2_id;

   always_comb
   begin
      adv[MUL_STAGES-1] = !stg_v[MUL_STAGES-1] || res_ready;
      for (int i = MUL_STAGES - 2; i >= 0; i--)
         adv[i] = !stg_v[i] || adv[i+1];      // free now or freed by the stage ahead.
   end

   assign rdy       = adv[0];
   assign res_valid = stg_v[MUL_STAGES-1];

   always_ff @(posedge clk)
   begin
      if (rst)
         stg_v <= '0;
      else
      begin
         if (adv[0])
            stg_v[0] <= req;
         for (int i = 1; i < MUL_STAGES; i++)
            if (adv[i])
               stg_v[i] <= stg_v[i-1];   // a bubble moves forward as well.
      end
   end

   always_ff @(posedge clk)
   begin
      if (req)
      begin
         s1_a   <= a;
         s1_b   <= b;
         s1_tag <= tag;
         s1_id  <= id;
      end
      if (adv[1] && stg_v[0])
      begin
         s2_prod <= s1_a * s1_b;
         s2_tag  <= s1_tag;
         s2_id   <= s1_id;
      end
      if (adv[MUL_STAGES-1] && stg_v[1])
      begin
         res_data <= s2_prod[XLEN-1:0];
         res_tag  <= s2_tag;
         res_id   <= s2_id;
      end
   end

   // a held product keeps its payload until the arbiter takes it.
   a_hold: assert property (@(posedge clk) disable iff (rst)
      res_valid && !res_ready |=> res_valid && $stable(res_data) && $stable(res_tag)
                                  && $stable(res_id));

endmodule

//--- div_unit.sv
////////////////////
// iterative unsigned divider, one restoring step per cycle.
// a single division is in flight, the op picks quotient or remainder.
////////////////////
`timescale 1ns/10ps

module div_unit import wb_pkg::*;
(
   input  logic              clk,
   input  logic              rst,
   input  logic              req,
   output logic              rdy,
   input  op_t               op,
   input  logic [XLEN-1:0]   a,
   input  logic [XLEN-1:0]   b,
   input  logic [TAG_W-1:0]  tag,
   input  logic [ID_W-1:0]   id,
   output logic              res_valid,
   input  logic              res_ready,
   output logic [XLEN-1:0]   res_data,
   output logic [TAG_W-1:0]  res_tag,
   output logic [ID_W-1:0]   res_id
);

   logic [DIV_CNT_W-1:0] cnt;                 // iterations left, zero when idle.
   logic                 busy;
   logic [XLEN-1:0]      quo_q;               // dividend shifts out, quotient shifts in.
   logic [XLEN-1:0]      rem_q;               // partial remainder.
   logic [XLEN-1:0]      dvs_q;               // divisor, held for the whole division.
   logic                 rem_sel;             // high for OP_REMU.
   logic [XLEN:0]        trial;               // shifted remainder minus divisor.

   assign busy     = (cnt != '0);
   assign rdy      = !busy && (!res_valid || res_ready);
   assign trial    = {rem_q, quo_q[XLEN-1]} - {1'b0, dvs_q};
   assign res_data = rem_sel ? rem_q : quo_q;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         cnt       <= '0;
         res_valid <= 1'b0;
      end
      else if (req)
      begin
         cnt       <= DIV_CNT_W'(DIV_CYCLES);
         res_valid <= 1'b0;                   // the previous result leaves on this same edge.
      end
      else if (busy)
      begin
         cnt <= cnt - 1'b1;
         if (cnt == DIV_CNT_W'(1))
            res_valid <= 1'b1;                // the last step lands the result.
      end
      else if (res_ready)
         res_valid <= 1'b0;
   end

   // with a zero divisor every trial succeeds, so the quotient fills with ones
   // and the remainder collects the dividend bit by bit.
   always_ff @(posedge clk)
   begin
      if (req)
      begin
         quo_q   <= a;
         rem_q   <= '0;
         dvs_q   <= b;
         rem_sel <= (op == OP_REMU);
         res_tag <= tag;
         res_id  <= id;
      end
      else if (busy)
      begin
         if (!trial[XLEN])
         begin
            rem_q <= trial[XLEN-1:0];         // no borrow, keep the difference.
            quo_q <= {quo_q[XLEN-2:0], 1'b1};
         end
         else
         begin
            rem_q <= {rem_q[XLEN-2:0], quo_q[XLEN-1]};  // borrow, restore the shift.
            quo_q <= {quo_q[XLEN-2:0], 1'b0};
         end
      end
   end

   // issue control must see rdy low for the whole division.
   a_no_req_busy: assert property (@(posedge clk) disable iff (rst)
      busy |-> !req);

endmodule

//--- wb_arbiter.sv
////////////////////
// fixed priority writeback arbiter, the lowest valid unit index wins.
// the granted payload goes to the reorder buffer port through an AND-OR mux.
////////////////////
`timescale 1ns/10ps

module wb_arbiter import wb_pkg::*;
(
   input  logic                        clk,
   input  logic                        rst,
   input  logic [N_FU-1:0]             res_valid,
   output logic [N_FU-1:0]             res_ready,
   input  logic [N_FU-1:0][XLEN-1:0]   res_data,
   input  logic [N_FU-1:0][TAG_W-1:0]  res_tag,
   input  logic [N_FU-1:0][ID_W-1:0]   res_id,
   output logic                        wb_valid,
   input  logic                        wb_ready,
   output logic [XLEN-1:0]             wb_data,
   output logic [TAG_W-1:0]            wb_tag,
   output logic [ID_W-1:0]             wb_id
);

   logic [N_FU-1:0] grant;

   assign grant     = res_valid & (~res_valid + 1'b1);  // isolates the lowest set bit.
   assign res_ready = grant & {N_FU{wb_ready}};          // only the winner sees the ready.
   assign wb_valid  = |res_valid;

   always_comb
   begin
      wb_data = '0;
      wb_tag  = '0;
      wb_id   = '0;
      for (int i = 0; i < N_FU; i++)
      begin
         wb_data = wb_data | (res_data[i] & {XLEN{grant[i]}});
         wb_tag  = wb_tag  | (res_tag[i]  & {TAG_W{grant[i]}});
         wb_id   = wb_id   | (res_id[i]   & {ID_W{grant[i]}});
      end
   end

   // at most one unit drives the port, and some unit does whenever it is valid.
   a_grant_onehot: assert property (@(posedge clk) disable iff (rst)
      $onehot0(grant));
   a_valid_grant: assert property (@(posedge clk) disable iff (rst)
      wb_valid == (|grant));

endmodule

//--- exu_top.sv
////////////////////
// execution and writeback slice, issue control feeding three units
// whose results merge onto one writeback port.
////////////////////
`timescale 1ns/10ps

module exu_top import wb_pkg::*;
(
   input  logic              clk,
   input  logic              rst,
   input  logic              in_valid,
   output logic              in_ready,
   input  op_t               in_op,
   input  logic [XLEN-1:0]   in_a,
   input  logic [XLEN-1:0]   in_b,
   input  logic [TAG_W-1:0]  in_tag,
   output logic              wb_valid,
   input  logic              wb_ready,
   output logic [XLEN-1:0]   wb_data,
   output logic [TAG_W-1:0]  wb_tag,
   output logic [ID_W-1:0]   wb_id
);

   logic                       alu_req, mul_req, div_req;
   logic                       alu_rdy, mul_rdy, div_rdy;
   op_t                        fu_op;
   logic [XLEN-1:0]            fu_a, fu_b;
   logic [TAG_W-1:0]           fu_tag;
   logic [ID_W-1:0]            fu_id;
   logic [N_FU-1:0]            res_valid;     // indexed by FU_DIV, FU_MUL and FU_ALU.
   logic [N_FU-1:0]            res_ready;
   logic [N_FU-1:0][XLEN-1:0]  res_data;
   logic [N_FU-1:0][TAG_W-1:0] res_tag;
   logic [N_FU-1:0][ID_W-1:0]  res_id;
   logic                       wb_fire;

   assign wb_fire = wb_valid && wb_ready;     // one in-flight slot is freed per transfer.

   issue_ctrl u_issue (.clk, .rst, .in_valid, .in_ready, .in_op, .in_a, .in_b, .in_tag,
      .alu_rdy, .mul_rdy, .div_rdy, .alu_req, .mul_req, .div_req,
      .fu_op, .fu_a, .fu_b, .fu_tag, .fu_id, .wb_fire);

   alu_unit u_alu (.clk, .rst, .req(alu_req), .rdy(alu_rdy), .op(fu_op), .a(fu_a), .b(fu_b),
      .tag(fu_tag), .id(fu_id), .res_valid(res_valid[FU_ALU]), .res_ready(res_ready[FU_ALU]),
      .res_data(res_data[FU_ALU]), .res_tag(res_tag[FU_ALU]), .res_id(res_id[FU_ALU]));

   mul_unit u_mul (.clk, .rst, .req(mul_req), .rdy(mul_rdy), .a(fu_a), .b(fu_b),
      .tag(fu_tag), .id(fu_id), .res_valid(res_valid[FU_MUL]), .res_ready(res_ready[FU_MUL]),
      .res_data(res_data[FU_MUL]), .res_tag(res_tag[FU_MUL]), .res_id(res_id[FU_MUL]));

   div_unit u_div (.clk, .rst, .req(div_req), .rdy(div_rdy), .op(fu_op), .a(fu_a), .b(fu_b),
      .tag(fu_tag), .id(fu_id), .res_valid(res_valid[FU_DIV]), .res_ready(res_ready[FU_DIV]),
      .res_data(res_data[FU_DIV]), .res_tag(res_tag[FU_DIV]), .res_id(res_id[FU_DIV]));

   wb_arbiter u_arb (.clk, .rst, .res_valid, .res_ready, .res_data, .res_tag, .res_id,
      .wb_valid, .wb_ready, .wb_data, .wb_tag, .wb_id);

endmodule

//--- tb_exu.sv
////////////////////
// testbench of the execution slice, drives issue traffic against a reference
// model and checks the writeback port with concurrent assertions.
////////////////////
`timescale 1ns/10ps

module tb_exu import wb_pkg::*;
;

   localparam int WAIT_MAX = 200;                // longest any single wait may run.

   logic                        clk = 1'b0;
   logic                        rst;
   logic                        in_valid;
   logic                        in_ready;
   op_t                         in_op;
   logic [XLEN-1:0]             in_a, in_b;
   logic [TAG_W-1:0]            in_tag;
   logic                        wb_valid;
   logic                        wb_ready = 1'b0;
   logic [XLEN-1:0]             wb_data;
   logic [TAG_W-1:0]            wb_tag;
   logic [ID_W-1:0]             wb_id;
   integer                      seed = 21239;
   int                          errors = 0;
   int                          cyc = 0;
   int                          iss_cnt, wb_cnt, issued_at, lone_lat, sent;
   logic [ROB_DEPTH-1:0]        pending;         // ids issued and not yet written back.
   logic [XLEN-1:0]             exp_data [ROB_DEPTH];
   logic [TAG_W-1:0]            exp_tag [ROB_DEPTH];
   logic [XLEN-1:0]             exp_wb_data;
   logic [TAG_W-1:0]            exp_wb_tag;
   logic [XLEN+TAG_W+ID_W-1:0]  prev_pay;        // writeback payload of the last cycle.
   logic                        rst_q = 1'b0;
   logic                        hold_q, refuse, done_q, wb_fire;
   logic [1:0]                  rdy_mode;        // 0 ready, 1 stalled, 2 random.

   always #4 clk = ~clk;

   exu_top dut_i (.*);

   assign wb_fire     = wb_valid && wb_ready;
   assign exp_wb_data = exp_data[wb_id];
   assign exp_wb_tag  = exp_tag[wb_id];

   // reference result of one operation, straight from the operation rules.
   function automatic logic [XLEN-1:0] model_result(input op_t op, input logic [XLEN-1:0] a,
                                                    input logic [XLEN-1:0] b);
      case (op)
         OP_ADD:  return a + b;
         OP_SUB:  return a - b;
         OP_AND:  return a & b;
         OP_OR:   return a | b;
         OP_XOR:  return a ^ b;
         OP_SLL:  return a << b[4:0];
         OP_SRL:  return a >> b[4:0];
         OP_MUL:  return a * b;                  // low half of the product.
         OP_DIVU: return (b == '0) ? '1 : a / b; // zero divisor gives all ones.
         OP_REMU: return (b == '0) ? a : a % b;  // zero divisor leaves the dividend.
         default: return '0;
      endcase
   endfunction

   // reference model and bookkeeping, all updated on the rising edge.
   always @(posedge clk)
   begin
      cyc      <= cyc + 1;
      rst_q    <= rst;
      hold_q   <= wb_valid && !wb_ready;         // a stalled writeback must hold next cycle.
      prev_pay <= {wb_data, wb_tag, wb_id};
      if (rst)
      begin
         iss_cnt <= 0;
         wb_cnt  <= 0;
         pending <= '0;
      end
      else
      begin
         if (in_valid && in_ready)
         begin
            exp_data[iss_cnt[ID_W-1:0]] <= model_result(in_op, in_a, in_b);
            exp_tag[iss_cnt[ID_W-1:0]]  <= in_tag;
            pending[iss_cnt[ID_W-1:0]]  <= 1'b1;  // ids follow the count of accepted issues.
            issued_at <= cyc;
            iss_cnt   <= iss_cnt + 1;
         end
         if (wb_fire)
         begin
            pending[wb_id] <= 1'b0;
            wb_cnt         <= wb_cnt + 1;
         end
      end
   end

   always @(posedge clk)
      case (rdy_mode)
         2'd0:    wb_ready <= 1'b1;
         2'd1:    wb_ready <= 1'b0;
         default: wb_ready <= ($random(seed) & 3) != 0;  // ready about three cycles in four.
      endcase

   task automatic report_mismatch(input string name, input logic [63:0] expected,
                                  input logic [63:0] actual);
      errors++;
      $display("FAIL %s expected %0h actual %0h", name, expected, actual);
   endtask

   task automatic fail_stop(input string why);
      errors++;
      $display("%s", why);
      $display("issued %0d written back %0d errors %0d", iss_cnt, wb_cnt, errors);
      $display("Errors found");
      $finish;
   endtask

   chk_data: assert property (@(posedge clk) disable iff (rst) wb_fire |-> wb_data == exp_wb_data)
      else report_mismatch("wb_data", 64'(exp_wb_data), 64'(wb_data));
   chk_tag: assert property (@(posedge clk) disable iff (rst) wb_fire |-> wb_tag == exp_wb_tag)
      else report_mismatch("wb_tag", 64'(exp_wb_tag), 64'(wb_tag));
   chk_once: assert property (@(posedge clk) disable iff (rst) wb_fire |-> pending[wb_id])
      else report_mismatch("wb_id_outstanding", 64'(1), 64'(pending[wb_id]));
   chk_hold: assert property (@(posedge clk) disable iff (rst)
      hold_q |-> {wb_valid, wb_data, wb_tag, wb_id} == {1'b1, prev_pay})
      else report_mismatch("wb_hold", 64'({1'b1, prev_pay}),
                           64'({wb_valid, wb_data, wb_tag, wb_id}));
   chk_latency: assert property (@(posedge clk) disable iff (rst)
      (lone_lat != 0) && wb_fire |-> (cyc - issued_at) == lone_lat)
      else report_mismatch("latency", 64'(lone_lat), 64'(cyc - issued_at));
   chk_refuse: assert property (@(posedge clk) disable iff (rst) refuse && in_valid |-> !in_ready)
      else report_mismatch("in_ready_refused", 64'(0), 64'(in_ready));
   chk_depth: assert property (@(posedge clk) disable iff (rst) (iss_cnt - wb_cnt) <= ROB_DEPTH)
      else report_mismatch("in_flight", 64'(ROB_DEPTH), 64'(iss_cnt - wb_cnt));
   chk_reset: assert property (@(posedge clk) rst_q |-> !in_ready && !wb_valid)
      else report_mismatch("reset_idle", 64'(0), 64'({in_ready, wb_valid}));
   chk_count: assert property (@(posedge clk) done_q |-> wb_cnt == iss_cnt)
      else report_mismatch("writeback_count", 64'(iss_cnt), 64'(wb_cnt));
   chk_drained: assert property (@(posedge clk) done_q |-> pending == '0)
      else report_mismatch("outstanding_ids", 64'(0), 64'(pending));

   // called on an edge, returns on the edge that accepts the operation.
   task automatic issue_op(input op_t op, input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
      int t;
      in_valid <= 1'b0;                          // dropped only while the next id is still owned.
      for (t = 0; pending[sent[ID_W-1:0]]; t++)
      begin
         if (t == WAIT_MAX)
            fail_stop("timeout waiting for a free reorder id");
         @(posedge clk);
      end
      in_valid <= 1'b1;
      in_op    <= op;
      in_a     <= a;
      in_b     <= b;
      in_tag   <= TAG_W'($random(seed));
      @(posedge clk);
      for (t = 0; !in_ready; t++)
      begin
         if (t == WAIT_MAX)
            fail_stop("timeout waiting for in_ready");
         @(posedge clk);
      end
      sent++;
   endtask

   task automatic wait_drain();
      int t;
      in_valid <= 1'b0;
      @(posedge clk);                            // lets the last issue reach the model.
      for (t = 0; pending != '0 || wb_valid; t++)
      begin
         if (t == WAIT_MAX)
            fail_stop("timeout waiting for outstanding writebacks");
         @(posedge clk);
      end
   endtask

   task automatic lone_op(input op_t op, input logic [XLEN-1:0] a, input logic [XLEN-1:0] b,
                          input int lat);
      lone_lat <= lat;
      issue_op(op, a, b);
      wait_drain();
   endtask

   initial
   begin
      int t;
      rst      = 1'b1;
      in_valid = 1'b0;
      in_op    = OP_ADD;
      in_a     = '0;
      in_b     = '0;
      in_tag   = '0;
      rdy_mode = 2'd0;
      lone_lat = 0;
      refuse   = 1'b0;
      done_q   = 1'b0;
      sent     = 0;
      repeat (8) @(posedge clk);
      rst <= 1'b0;
      @(posedge clk);

      // single operations into an idle slice, every operation kind once.
      lone_op(OP_ADD, 32'hffff_fff0, 32'h0000_0025, 1);
      lone_op(OP_SUB, 32'h0000_0003, 32'h0000_0005, 1);
      lone_op(OP_AND, 32'hf0f0_1234, 32'h0ff0_ffff, 1);
      lone_op(OP_OR, 32'h1200_0034, 32'h0056_7800, 1);
      lone_op(OP_XOR, 32'haaaa_5555, 32'hffff_0000, 1);
      lone_op(OP_SLL, 32'h8000_0001, 32'h0000_0023, 1);   // only the low five bits count.
      lone_op(OP_SRL, 32'h8000_0001, 32'hffff_ffe1, 1);
      lone_op(OP_MUL, 32'h1234_5678, 32'h9abc_def0, MUL_STAGES);
      lone_op(OP_DIVU, 32'hdead_beef, 32'h0000_1234, DIV_CYCLES + 1);
      lone_op(OP_REMU, 32'hdead_beef, 32'h0000_1234, DIV_CYCLES + 1);
      lone_op(OP_DIVU, 32'h0bad_f00d, 32'h0000_0000, DIV_CYCLES + 1);
      lone_op(OP_REMU, 32'h0bad_f00d, 32'h0000_0000, DIV_CYCLES + 1);
      lone_lat <= 0;

      // mixed traffic with the port always ready, so results leave out of order.
      repeat (48)
         issue_op(op_t'(4'($unsigned($random(seed)) % 10)), $random(seed), $random(seed));
      wait_drain();

      // a newly valid unit of higher priority takes over the port, so random
      // back-pressure is applied to one unit kind at a time.
      rdy_mode <= 2'd2;
      repeat (24)
         issue_op(op_t'(4'($unsigned($random(seed)) % 7)), $random(seed), $random(seed));
      wait_drain();
      repeat (12)
         issue_op(OP_MUL, $random(seed), $random(seed));
      wait_drain();
      repeat (4)
         issue_op(($random(seed) & 1) ? OP_REMU : OP_DIVU, $random(seed),
                  {16'h0, 16'($random(seed))});
      wait_drain();

      // stalled port, more attempts than there are ids, the multiplier fills
      // and issue must stop.
      rdy_mode <= 2'd1;
      in_valid <= 1'b1;
      in_op    <= OP_MUL;
      repeat (ROB_DEPTH + 4)
      begin
         @(posedge clk);
         if (in_ready)
         begin
            sent++;
            in_a <= $random(seed);               // the next product once one is taken.
            in_b <= $random(seed);
         end
      end
      refuse <= 1'b1;
      repeat (8) @(posedge clk);
      refuse   <= 1'b0;
      rdy_mode <= 2'd0;
      wait_drain();

      // stalled port, a second division waits behind the held first one.
      rdy_mode <= 2'd1;
      issue_op(OP_DIVU, 32'h0001_0000, 32'h0000_0007);
      in_a   <= 32'h0000_0100;
      refuse <= 1'b1;
      for (t = 0; !wb_valid; t++)
      begin
         if (t == WAIT_MAX)
            fail_stop("timeout waiting for the held division result");
         @(posedge clk);
      end
      repeat (8) @(posedge clk);
      refuse   <= 1'b0;
      in_valid <= 1'b0;
      rdy_mode <= 2'd0;
      wait_drain();

      done_q <= 1'b1;                            // arms the final count checks.
      repeat (2) @(posedge clk);
      $display("issued %0d written back %0d errors %0d", iss_cnt, wb_cnt, errors);
      if (errors == 0)
         $display("No errors");
      else
         $display("Errors found");
      $finish;
   end

endmodule

//--- sources.f
wb_pkg.sv
issue_ctrl.sv
alu_unit.sv
mul_unit.sv
div_unit.sv
wb_arbiter.sv
exu_top.sv
tb_exu.sv

//--- Makefile
# Verilator build, run and lint of the execution slice testbench.
VERILATOR ?= verilator
TOP       ?= tb_exu
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
PASS_MSG  ?= No errors
TSCALE    ?= 1ns/10ps
VFLAGS    ?= --binary --timing --assert --timescale $(TSCALE) -j 0
LINTFLAGS ?= --lint-only -Wall --timing --assert --timescale $(TSCALE)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
